// File: hdl/mul_dp_pkg.sv
// datapath definitions for the shared CSD multiplier
// widths, vector types and the structs passed between pipeline stages
package mul_dp_pkg;

    // ========================================
    // widths
    localparam int SAMPLE_W  = 16;
    localparam int ACC_W     = 32;
    localparam int SEL_W     = 4;
    localparam int MAX_TERMS = 8;

    // ========================================
    // vector types
    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [ACC_W-1:0]    acc_t;
    typedef logic        [SEL_W-1:0]    coef_sel_t;

    // ========================================
    // stage structs
    typedef struct packed {
        logic      valid;
        coef_sel_t sel;
        sample_t   x;
    } mul_req_t;

    typedef struct packed {
        logic valid;
        acc_t y;
    } mul_rsp_t;

    // signed shifted terms out of decode
    typedef struct packed {
        logic                   valid;
        acc_t [MAX_TERMS-1:0]   term;
    } term_vec_t;

    // redundant form out of the compressor tree
    // carry still needs its one place shift
    typedef struct packed {
        logic valid;
        acc_t sum;
        acc_t carry;
    } sc_pair_t;

endpackage

// File: hdl/csd_coef_pkg.sv
// CSD digit table for the H1 and H3 coefficient groups
// every coefficient is a signed sum of up to eight powers of two
package csd_coef_pkg;

    typedef logic [4:0] shift_t;

    // digit is worth +/- 2^shift when en is set
    typedef struct packed {
        logic   en;
        logic   neg;
        shift_t shift;
    } csd_digit_t;

    localparam int NUM_COEFS = 12;

    // en and neg bits of a digit
    localparam logic [1:0] PLUS  = 2'b10;
    localparam logic [1:0] MINUS = 2'b11;

    // empty digit slot
    localparam csd_digit_t OFF = '0;

    localparam csd_digit_t COEF_TABLE [NUM_COEFS][mul_dp_pkg::MAX_TERMS] = '{
        // ========================================
        // h1 group covers indices 0 to 5
        // -146
        '{{MINUS, 5'd7}, {MINUS, 5'd4}, {MINUS, 5'd1}, OFF,
          OFF, OFF, OFF, OFF},
        // -1021
        '{{MINUS, 5'd10}, {PLUS, 5'd2}, {MINUS, 5'd0}, OFF,
          OFF, OFF, OFF, OFF},
        // -5548
        '{{MINUS, 5'd13}, {PLUS, 5'd11}, {PLUS, 5'd9}, {PLUS, 5'd6},
          {PLUS, 5'd4}, {PLUS, 5'd2}, OFF, OFF},
        // 12491
        '{{PLUS, 5'd14}, {MINUS, 5'd12}, {PLUS, 5'd8}, {MINUS, 5'd6},
          {PLUS, 5'd4}, {MINUS, 5'd2}, {MINUS, 5'd0}, OFF},
        // 3226
        '{{PLUS, 5'd12}, {MINUS, 5'd10}, {PLUS, 5'd7}, {PLUS, 5'd5},
          {MINUS, 5'd3}, {PLUS, 5'd1}, OFF, OFF},
        // 1221
        '{{PLUS, 5'd10}, {PLUS, 5'd8}, {MINUS, 5'd6}, {PLUS, 5'd2},
          {PLUS, 5'd0}, OFF, OFF, OFF},
        // ========================================
        // h3 group covers indices 6 to 11
        // 367
        '{{PLUS, 5'd9}, {MINUS, 5'd7}, {MINUS, 5'd4}, {MINUS, 5'd0},
          OFF, OFF, OFF, OFF},
        // 2242
        '{{PLUS, 5'd11}, {PLUS, 5'd8}, {MINUS, 5'd6}, {PLUS, 5'd1},
          OFF, OFF, OFF, OFF},
        // 33782, largest magnitude in the table
        '{{PLUS, 5'd15}, {PLUS, 5'd10}, {MINUS, 5'd3}, {MINUS, 5'd1},
          OFF, OFF, OFF, OFF},
        // -5415
        '{{MINUS, 5'd12}, {MINUS, 5'd10}, {MINUS, 5'd8}, {MINUS, 5'd5},
          {MINUS, 5'd3}, {PLUS, 5'd0}, OFF, OFF},
        // -1961
        '{{MINUS, 5'd11}, {PLUS, 5'd7}, {MINUS, 5'd5}, {MINUS, 5'd3},
          {MINUS, 5'd0}, OFF, OFF, OFF},
        // -835
        '{{MINUS, 5'd10}, {PLUS, 5'd8}, {MINUS, 5'd6}, {MINUS, 5'd2},
          {PLUS, 5'd0}, OFF, OFF, OFF}
    };

endpackage

// File: hdl/csd_decode.sv
`timescale 1ns/1ps

// CSD decode stage
// looks up the coefficient digits and forms the signed shifted terms
module csd_decode (
    input  logic                  clk,
    input  logic                  arst_n,
    input  mul_dp_pkg::mul_req_t  req,
    output mul_dp_pkg::term_vec_t terms
);

    mul_dp_pkg::acc_t                             x_ext;
    mul_dp_pkg::acc_t [mul_dp_pkg::MAX_TERMS-1:0] term_d;

    // sample widened to product width
    assign x_ext = {{(mul_dp_pkg::ACC_W - mul_dp_pkg::SAMPLE_W){req.x[mul_dp_pkg::SAMPLE_W-1]}},
                    req.x};

    // ========================================
    // digit lookup and term forming
    always_comb begin
        csd_coef_pkg::csd_digit_t digit;

        for (int i = 0; i < mul_dp_pkg::MAX_TERMS; i++) begin
            if (req.sel < csd_coef_pkg::NUM_COEFS) begin
                digit = csd_coef_pkg::COEF_TABLE[req.sel][i];
            end else begin
                // indices past the table give a zero product
                digit = '0;
            end

            if (!digit.en) begin
                term_d[i] = '0;
            end else if (digit.neg) begin
                term_d[i] = -(x_ext << digit.shift);
            end else begin
                term_d[i] = x_ext << digit.shift;
            end
        end
    end

    // ========================================
    // stage register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            terms <= '0;
        end else begin
            terms.valid <= req.valid;
            // hold terms between requests
            if (req.valid) begin
                terms.term <= term_d;
            end
        end
    end

endmodule

// File: hdl/csa_execute.sv
`timescale 1ns/1ps

// carry-save execute stage
// compresses eight shifted terms to a sum and carry pair with 3:2 levels
module csa_execute (
    input  logic                  clk,
    input  logic                  arst_n,
    input  mul_dp_pkg::term_vec_t terms,
    output mul_dp_pkg::sc_pair_t  sc
);

    // per level operands, carries already aligned
    mul_dp_pkg::acc_t lvl1 [6];
    mul_dp_pkg::acc_t lvl2 [4];
    mul_dp_pkg::acc_t lvl3 [3];
    mul_dp_pkg::acc_t sum_d;
    mul_dp_pkg::acc_t carry_d;

    // full adder sum bit per column
    function automatic mul_dp_pkg::acc_t csa_sum(
        input mul_dp_pkg::acc_t a,
        input mul_dp_pkg::acc_t b,
        input mul_dp_pkg::acc_t c
    );
        return a ^ b ^ c;
    endfunction

    // majority gives the carry out of each column
    function automatic mul_dp_pkg::acc_t csa_carry(
        input mul_dp_pkg::acc_t a,
        input mul_dp_pkg::acc_t b,
        input mul_dp_pkg::acc_t c
    );
        return (a & b) | (b & c) | (a & c);
    endfunction

    // ========================================
    // level 1, eight to six
    assign lvl1[0] = csa_sum(terms.term[0], terms.term[1], terms.term[2]);
    assign lvl1[1] = csa_carry(terms.term[0], terms.term[1], terms.term[2]) << 1;
    assign lvl1[2] = csa_sum(terms.term[3], terms.term[4], terms.term[5]);
    assign lvl1[3] = csa_carry(terms.term[3], terms.term[4], terms.term[5]) << 1;
    assign lvl1[4] = terms.term[6];
    assign lvl1[5] = terms.term[7];

    // ========================================
    // level 2, six to four
    assign lvl2[0] = csa_sum(lvl1[0], lvl1[1], lvl1[2]);
    assign lvl2[1] = csa_carry(lvl1[0], lvl1[1], lvl1[2]) << 1;
    assign lvl2[2] = csa_sum(lvl1[3], lvl1[4], lvl1[5]);
    assign lvl2[3] = csa_carry(lvl1[3], lvl1[4], lvl1[5]) << 1;

    // level 3, four to three
    assign lvl3[0] = csa_sum(lvl2[0], lvl2[1], lvl2[2]);
    assign lvl3[1] = csa_carry(lvl2[0], lvl2[1], lvl2[2]) << 1;
    assign lvl3[2] = lvl2[3];

    // level 4, three to two
    // carry leaves unshifted, the result stage aligns it
    assign sum_d   = csa_sum(lvl3[0], lvl3[1], lvl3[2]);
    assign carry_d = csa_carry(lvl3[0], lvl3[1], lvl3[2]);

    // ========================================
    // stage register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sc <= '0;
        end else begin
            sc.valid <= terms.valid;
            if (terms.valid) begin
                sc.sum   <= sum_d;
                sc.carry <= carry_d;
            end
        end
    end

endmodule

// File: hdl/cpa_result.sv
`timescale 1ns/1ps

// result stage
// carry-propagate add of the sum and carry pair into the final product
module cpa_result (
    input  logic                 clk,
    input  logic                 arst_n,
    input  mul_dp_pkg::sc_pair_t sc,
    output mul_dp_pkg::mul_rsp_t rsp
);

    mul_dp_pkg::acc_t y_d;

    // wraps modulo 2^32
    // every kept product still fits in 32 signed bits
    assign y_d = sc.sum + (sc.carry << 1);

    // ========================================
    // output register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp <= '0;
        end else begin
            // strobe lasts one cycle per request
            rsp.valid <= sc.valid;
            if (sc.valid) begin
                rsp.y <= y_d;
            end
        end
    end

endmodule

// File: hdl/csd_mul_top.sv
`timescale 1ns/1ps

// shared CSD constant multiplier
// three stage pipeline of decode, carry-save tree and final add
module csd_mul_top (
    input  logic                 clk,
    input  logic                 arst_n,
    input  mul_dp_pkg::mul_req_t req,
    output mul_dp_pkg::mul_rsp_t rsp
);

    // stage 1 to stage 2
    mul_dp_pkg::term_vec_t terms;
    // stage 2 to stage 3
    mul_dp_pkg::sc_pair_t  sc;

    // ========================================
    // pipeline stages
    csd_decode u_decode (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .terms  (terms)
    );

    csa_execute u_execute (
        .clk    (clk),
        .arst_n (arst_n),
        .terms  (terms),
        .sc     (sc)
    );

    // product leaves three edges after the request
    cpa_result u_result (
        .clk    (clk),
        .arst_n (arst_n),
        .sc     (sc),
        .rsp    (rsp)
    );

endmodule

// File: testbench/tb_vectors.svh
// stimulus table layout and coefficient values for the CSD multiplier testbench
// rows are driven one per cycle, idle rows leave the request strobe low
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// ========================================
// run lengths
localparam int RESET_CYCLES   = 10;
localparam int PIPE_DEPTH     = 3;
localparam int NUM_INDEX      = 16;
localparam int NUM_KEPT       = 12;
localparam int IDLE_LEAD      = 4;
localparam int IDLE_GAP       = 2;
localparam int NUM_UNIT       = NUM_KEPT;
localparam int NUM_EXTREME    = 2 * NUM_KEPT;
localparam int NUM_ZERO       = 2 * (NUM_INDEX - NUM_KEPT);
localparam int NUM_RANDOM     = 24;
localparam int TABLE_LEN      = IDLE_LEAD + NUM_UNIT + NUM_EXTREME + NUM_ZERO
                                + IDLE_GAP + NUM_RANDOM;
localparam int TIMEOUT_MARGIN = 20;
localparam int CYCLE_LIMIT    = RESET_CYCLES + TABLE_LEN + PIPE_DEPTH + TIMEOUT_MARGIN;

// extreme samples
localparam mul_dp_pkg::sample_t SAMPLE_MIN = 16'sh8000;
localparam mul_dp_pkg::sample_t SAMPLE_MAX = 16'sh7fff;

// ========================================
// row kinds
localparam logic [2:0] KIND_IDLE    = 3'd0;
localparam logic [2:0] KIND_UNIT    = 3'd1;
localparam logic [2:0] KIND_EXTREME = 3'd2;
localparam logic [2:0] KIND_ZERO    = 3'd3;
localparam logic [2:0] KIND_RANDOM  = 3'd4;

typedef struct packed {
    logic [2:0]            kind;
    logic                  valid;
    mul_dp_pkg::coef_sel_t sel;
    mul_dp_pkg::sample_t   x;
    mul_dp_pkg::acc_t      expected;
} vec_t;

// coefficient value per index, unused indices multiply by zero
localparam int COEF_VALUE [NUM_INDEX] = '{
    -146, -1021, -5548, 12491, 3226, 1221,
    367, 2242, 33782, -5415, -1961, -835,
    0, 0, 0, 0
};

function automatic string kind_name(input logic [2:0] kind);
    case (kind)
        KIND_UNIT:    return "unit sample";
        KIND_EXTREME: return "extreme sample";
        KIND_ZERO:    return "unused index";
        KIND_RANDOM:  return "back to back";
        default:      return "idle";
    endcase
endfunction

`endif

// File: testbench/tb_csd_mul.sv
`timescale 1ns/1ps

// testbench for the shared CSD constant multiplier
// drives the stimulus table and checks each product and its latency
module tb_csd_mul;

    `include "tb_vectors.svh"

    typedef struct packed {
        int idx;
        int due;
    } pending_t;

    logic                 clk;
    logic                 arst_n;
    mul_dp_pkg::mul_req_t req;
    mul_dp_pkg::mul_rsp_t rsp;

    vec_t     vectors [TABLE_LEN];
    pending_t pending [$];
    int       seed = 36;
    int       cycles;
    int       error_count;
    int       tests_passed;
    int       tests_failed;
    int       request_count;
    int       response_count;

    csd_mul_top UUT (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .rsp    (rsp)
    );

    // ========================================
    // clock and cycle limit
    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles, responses still missing", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // ========================================
    // expected values and table
    function automatic mul_dp_pkg::acc_t expected_product(input mul_dp_pkg::coef_sel_t sel,
                                                          input mul_dp_pkg::sample_t x);
        longint p;

        p = longint'(COEF_VALUE[sel]) * longint'(x);
        return mul_dp_pkg::acc_t'(p);
    endfunction

    task automatic add_row(inout int n, input logic [2:0] kind, input logic valid,
                           input mul_dp_pkg::coef_sel_t sel, input mul_dp_pkg::sample_t x);
        vectors[n].kind     = kind;
        vectors[n].valid    = valid;
        vectors[n].sel      = sel;
        vectors[n].x        = x;
        vectors[n].expected = valid ? expected_product(sel, x) : '0;
        n++;
    endtask

    task automatic build_table();
        int n;

        n = 0;
        for (int i = 0; i < IDLE_LEAD; i++) begin
            add_row(n, KIND_IDLE, 1'b0, '0, '0);
        end
        for (int s = 0; s < NUM_KEPT; s++) begin
            add_row(n, KIND_UNIT, 1'b1, s, 16'sd1);
        end
        for (int s = 0; s < NUM_KEPT; s++) begin
            add_row(n, KIND_EXTREME, 1'b1, s, SAMPLE_MIN);
            add_row(n, KIND_EXTREME, 1'b1, s, SAMPLE_MAX);
        end
        for (int s = NUM_KEPT; s < NUM_INDEX; s++) begin
            add_row(n, KIND_ZERO, 1'b1, s, SAMPLE_MIN);
            add_row(n, KIND_ZERO, 1'b1, s, mul_dp_pkg::sample_t'($random(seed)));
        end
        for (int i = 0; i < IDLE_GAP; i++) begin
            add_row(n, KIND_IDLE, 1'b0, '0, '0);
        end
        // one request per cycle, any index
        for (int i = 0; i < NUM_RANDOM; i++) begin
            add_row(n, KIND_RANDOM, 1'b1, mul_dp_pkg::coef_sel_t'($random(seed)),
                    mul_dp_pkg::sample_t'($random(seed)));
        end
    endtask

    // ========================================
    // compare tasks
    task automatic check_product(input string name, input mul_dp_pkg::acc_t got,
                                 input mul_dp_pkg::acc_t exp, output bit ok);
        ok = (got === exp);
        if (!ok) begin
            error_count++;
            $display("ERROR at %0d ns: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_valid(input string name, input logic got, input logic exp,
                               output bit ok);
        ok = (got === exp);
        if (!ok) begin
            error_count++;
            $display("ERROR at %0d ns: %s got %0b expected %0b", $time, name, got, exp);
        end
    endtask

    // ========================================
    // drive and sample, both on the falling edge
    task automatic drive_entry(input int i);
        pending_t p;

        req.valid = vectors[i].valid;
        req.sel   = vectors[i].sel;
        req.x     = vectors[i].x;
        if (vectors[i].valid) begin
            // sampled at the next rising edge, product registered two edges after that
            p.idx = i;
            p.due = cycles + PIPE_DEPTH;
            pending.push_back(p);
            request_count++;
        end
    endtask

    task automatic check_outputs();
        bit       ok_v;
        bit       ok_y;
        logic     exp_valid;
        pending_t p;
        vec_t     row;

        exp_valid = (pending.size() > 0) && (pending[0].due == cycles);
        if (rsp.valid === 1'b1) begin
            response_count++;
        end
        check_valid("rsp.valid", rsp.valid, exp_valid, ok_v);
        if (exp_valid) begin
            p   = pending.pop_front();
            row = vectors[p.idx];
            ok_y = 1'b0;
            if (rsp.valid === 1'b1) begin
                check_product("rsp.y", rsp.y, row.expected, ok_y);
            end
            if (ok_v && ok_y) begin
                tests_passed++;
            end else begin
                tests_failed++;
            end
            $display("test %0d %s sel=%0d x=%0d y=%0d %s", p.idx, kind_name(row.kind),
                     row.sel, row.x, rsp.y, (ok_v && ok_y) ? "ok" : "failed");
        end
    endtask

    // ========================================
    // main sequence
    initial begin
        bit ok;

        arst_n = 1'b0;
        req    = '0;
        cycles = 0;
        error_count    = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        request_count  = 0;
        response_count = 0;
        build_table();

        repeat (RESET_CYCLES) @(negedge clk);
        // outputs cleared while reset is held
        check_valid("rsp.valid", rsp.valid, 1'b0, ok);
        check_product("rsp.y", rsp.y, '0, ok);
        arst_n = 1'b1;

        for (int i = 0; i < TABLE_LEN; i++) begin
            @(negedge clk);
            check_outputs();
            drive_entry(i);
        end

        // drain the pipeline, then watch for stray strobes
        while (pending.size() > 0) begin
            @(negedge clk);
            check_outputs();
            req = '0;
        end
        repeat (2) begin
            @(negedge clk);
            check_outputs();
        end

        if (response_count != request_count) begin
            error_count++;
            $display("response count %0d does not match %0d requests",
                     response_count, request_count);
        end

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+testbench
hdl/mul_dp_pkg.sv
hdl/csd_coef_pkg.sv
hdl/csd_decode.sv
hdl/csa_execute.sv
hdl/cpa_result.sv
hdl/csd_mul_top.sv
testbench/tb_csd_mul.sv
